// ==== Bender.yml ====
package:
  name: ooo_core

sources:
  - design/ooo_pkg.sv
  - design/reservation_station.sv
  - design/fu_lane.sv
  - design/cdb_arbiter.sv
  - design/ooo_core.sv
  - target: test
    files:
      - bench/clock_gen.sv
      - bench/ooo_core_tb.sv

// ==== bench/clock_gen.sv ====
// testbench clock and reset source
`timescale 1ns/1ns
`default_nettype none

module clock_gen #(
  parameter int PERIOD       = 100,
  parameter int RESET_CYCLES = 5
) (
  output logic clock,
  output logic reset
);

  // free-running clock, low at time zero
  initial begin
    clock = 1'b0;
    forever #(PERIOD / 2) clock = ~clock;
  end

  // reset seen high by the first RESET_CYCLES rising edges
  initial begin
    reset = 1'b1;
    repeat (RESET_CYCLES) @(posedge clock);
    reset <= 1'b0;
  end

endmodule

`default_nettype wire

// ==== bench/ooo_core_tb.sv ====
// testbench for the out-of-order back end
// random stimulus, tag model with reference function, cdb monitor
// compare tasks and watchdog
`timescale 1ns/1ns
`default_nettype none

module ooo_core_tb import ooo_pkg::*; ();

  localparam int RS_SIZE      = 8;
  localparam int NUM_LANES    = 3;
  localparam int MULT_LATENCY = 4;
  localparam int NUM_TAGS     = 1 << TAG_WIDTH;
  // dispatches per section in test order
  localparam int TOTAL_OPS       = 12 + 12 + 4 + 40 + 14;
  localparam int WATCHDOG_CYCLES = 20 * TOTAL_OPS * (MULT_LATENCY + RS_SIZE);

  logic      clock;
  logic      reset;
  logic      dispatch_valid;
  alu_func_t dispatch_func;
  tag_t      dispatch_dest;
  logic      dispatch_a_ready;
  operand_t  dispatch_a;
  logic      dispatch_b_ready;
  operand_t  dispatch_b;
  logic      rs_full;
  logic      cdb_valid;
  tag_t      cdb_tag;
  word_t     cdb_value;

  // tag model with one slot per tag
  logic      pending [NUM_TAGS];
  word_t     known [NUM_TAGS];
  alu_func_t ins_func [NUM_TAGS];
  logic      ra [NUM_TAGS];
  logic      rb [NUM_TAGS];
  word_t     va [NUM_TAGS];
  word_t     vb [NUM_TAGS];
  tag_t      wa [NUM_TAGS];
  tag_t      wb [NUM_TAGS];

  integer    seed;
  int        pending_count;
  int        bypass_hits;
  logic      saw_full;

  clock_gen #(
    .PERIOD       (100),
    .RESET_CYCLES (5)
  ) u_clock (
    .clock (clock),
    .reset (reset)
  );

  ooo_core #(
    .RS_SIZE      (RS_SIZE),
    .NUM_LANES    (NUM_LANES),
    .MULT_LATENCY (MULT_LATENCY)
  ) uut (
    .clock            (clock),
    .reset            (reset),
    .dispatch_valid   (dispatch_valid),
    .dispatch_func    (dispatch_func),
    .dispatch_dest    (dispatch_dest),
    .dispatch_a_ready (dispatch_a_ready),
    .dispatch_a       (dispatch_a),
    .dispatch_b_ready (dispatch_b_ready),
    .dispatch_b       (dispatch_b),
    .rs_full          (rs_full),
    .cdb_valid        (cdb_valid),
    .cdb_tag          (cdb_tag),
    .cdb_value        (cdb_value)
  );

  //////////////////////////////////////////////////////////////////////
  // reference model and compare tasks
  //////////////////////////////////////////////////////////////////////

  function automatic word_t expected_result(input alu_func_t func, input word_t a,
                                            input word_t b);
    logic [2*WORD_WIDTH-1:0] product;
    // full product with the low word kept
    product = {{WORD_WIDTH{1'b0}}, a} * {{WORD_WIDTH{1'b0}}, b};
    case (func)
      FUNC_ADD: return a + b;
      FUNC_SUB: return a + ~b + 1'b1;
      FUNC_AND: return a & b;
      FUNC_OR:  return a | b;
      FUNC_XOR: return a ^ b;
      FUNC_MUL: return product[WORD_WIDTH-1:0];
      default:  return '0;
    endcase
  endfunction

  task automatic stop_run();
    $display("Simulation failed");
    $fatal(1, "stopping at the first error");
  endtask

  task automatic check_value(input string name, input word_t expected, input word_t actual);
    if (actual !== expected) begin
      $display("ERROR at %0t ns: %s expected %h, got %h", $time, name, expected, actual);
      stop_run();
    end
  endtask

  task automatic check_tag(input string name, input tag_t expected, input tag_t actual);
    if (actual !== expected) begin
      $display("ERROR at %0t ns: %s expected %0d, got %0d", $time, name, expected, actual);
      stop_run();
    end
  endtask

  task automatic check_flag(input string name, input logic expected, input logic actual);
    if (actual !== expected) begin
      $display("ERROR at %0t ns: %s expected %b, got %b", $time, name, expected, actual);
      stop_run();
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // stimulus helpers called at a falling edge
  //////////////////////////////////////////////////////////////////////

  // value if already broadcast and the tag otherwise
  task automatic resolve_src(input tag_t t, output logic rdy, output word_t w);
    if (pending[t]) begin
      rdy = 1'b0;
      w   = word_t'(t);
    end else begin
      rdy = 1'b1;
      w   = known[t];
    end
  endtask

  task automatic pick_tag(input logic want_pending, output logic found, output tag_t t);
    int start;
    int idx;
    found = 1'b0;
    t     = '0;
    start = $unsigned($random(seed)) % NUM_TAGS;
    for (int k = 0; k < NUM_TAGS; k++) begin
      idx = (start + k) % NUM_TAGS;
      if (!found && (pending[idx] == want_pending)) begin
        found = 1'b1;
        t     = tag_t'(idx);
      end
    end
  endtask

  task automatic pick_free(output tag_t t);
    logic found;
    pick_tag(1'b0, found, t);
    if (!found) begin
      $display("no free tag left for a new dispatch at %0t ns", $time);
      stop_run();
    end
  endtask

  // random source that waits on an in-flight tag half the time
  task automatic make_src(output logic rdy, output word_t w);
    logic coin;
    logic found;
    tag_t t;
    coin = ($random(seed) & 1) != 0;
    pick_tag(1'b1, found, t);
    if (coin && found) begin
      resolve_src(t, rdy, w);
    end else begin
      rdy = 1'b1;
      w   = $random(seed);
    end
  endtask

  // strobe held while full
  // returns at the falling edge after acceptance
  task automatic send(input alu_func_t func, input tag_t dest, input logic a_rdy,
                      input word_t a, input logic b_rdy, input word_t b);
    logic  held;
    logic  ar;
    logic  br;
    word_t av;
    word_t bv;
    ar   = a_rdy;
    av   = a;
    br   = b_rdy;
    bv   = b;
    held = 1'b1;
    while (held) begin
      dispatch_valid   = 1'b1;
      dispatch_func    = func;
      dispatch_dest    = dest;
      dispatch_a_ready = ar;
      dispatch_a.value = av;
      dispatch_b_ready = br;
      dispatch_b.value = bv;
      held             = rs_full;
      @(negedge clock);
      // producer may have broadcast while we were held off
      if (held && !ar) resolve_src(tag_t'(av), ar, av);
      if (held && !br) resolve_src(tag_t'(bv), br, bv);
    end
    dispatch_valid = 1'b0;
  endtask

  task automatic wait_drain();
    while (pending_count != 0) @(negedge clock);
  endtask

  //////////////////////////////////////////////////////////////////////
  // monitor that records accepted dispatches and checks each broadcast
  //////////////////////////////////////////////////////////////////////

  always @(posedge clock) begin : monitor
    tag_t  d;
    tag_t  t;
    word_t expected;
    if (!reset) begin
      if (rs_full) saw_full = 1'b1;
      if (dispatch_valid && !rs_full) begin
        d           = dispatch_dest;
        pending[d]  = 1'b1;
        ins_func[d] = dispatch_func;
        ra[d]       = dispatch_a_ready;
        va[d]       = dispatch_a.value;
        wa[d]       = dispatch_a.pending.tag;
        rb[d]       = dispatch_b_ready;
        vb[d]       = dispatch_b.value;
        wb[d]       = dispatch_b.pending.tag;
        pending_count++;
        // source named on the bus at the edge it lands
        if (cdb_valid && ((!ra[d] && wa[d] == cdb_tag) || (!rb[d] && wb[d] == cdb_tag)))
          bypass_hits++;
      end
      if (cdb_valid) begin
        t = cdb_tag;
        if (!pending[t]) begin
          $display("tag %0d broadcast at %0t ns while not in flight", t, $time);
          stop_run();
        end else if (!ra[t] || !rb[t]) begin
          $display("tag %0d broadcast at %0t ns before its sources were known", t, $time);
          stop_run();
        end else begin
          expected = expected_result(ins_func[t], va[t], vb[t]);
          check_value($sformatf("cdb_value of tag %0d", t), expected, cdb_value);
          pending[t] = 1'b0;
          known[t]   = expected;
          pending_count--;
          // wake waiters in the model
          for (int k = 0; k < NUM_TAGS; k++) begin
            if (pending[k] && !ra[k] && wa[k] == t) begin
              ra[k] = 1'b1;
              va[k] = expected;
            end
            if (pending[k] && !rb[k] && wb[k] == t) begin
              rb[k] = 1'b1;
              vb[k] = expected;
            end
          end
        end
      end
    end
  end

  // run length bound
  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clock);
    $display("watchdog expired after %0d cycles, %0d tags in flight",
             WATCHDOG_CYCLES, pending_count);
    stop_run();
  end

  //////////////////////////////////////////////////////////////////////
  // test sequence
  //////////////////////////////////////////////////////////////////////

  initial begin : stimulus
    tag_t      d;
    tag_t      prev;
    logic      ar;
    logic      br;
    word_t     av;
    word_t     bv;
    alu_func_t func;
    seed             = 96;
    dispatch_valid   = 1'b0;
    dispatch_func    = FUNC_ADD;
    dispatch_dest    = '0;
    dispatch_a_ready = 1'b0;
    dispatch_a       = '0;
    dispatch_b_ready = 1'b0;
    dispatch_b       = '0;
    pending_count    = 0;
    bypass_hits      = 0;
    saw_full         = 1'b0;
    for (int k = 0; k < NUM_TAGS; k++) begin
      pending[k] = 1'b0;
      known[k]   = '0;
    end

    // quiet outputs during reset and one cycle after
    @(posedge clock);
    @(negedge clock);
    while (reset) begin
      check_flag("rs_full", 1'b0, rs_full);
      check_flag("cdb_valid", 1'b0, cdb_valid);
      @(negedge clock);
    end
    check_flag("rs_full", 1'b0, rs_full);
    check_flag("cdb_valid", 1'b0, cdb_valid);

    // independent ops covering every function twice
    for (int i = 0; i < 12; i++) begin
      pick_free(d);
      send(alu_func_t'(i % 6), d, 1'b1, $random(seed), 1'b1, $random(seed));
    end
    wait_drain();

    // three chains of four
    for (int c = 0; c < 3; c++) begin
      pick_free(prev);
      send(FUNC_MUL, prev, 1'b1, $random(seed), 1'b1, $random(seed));
      for (int i = 1; i < 4; i++) begin
        resolve_src(prev, ar, av);
        pick_free(d);
        send(alu_func_t'($unsigned($random(seed)) % 6), d, ar, av, 1'b1, $random(seed));
        prev = d;
      end
    end
    wait_drain();

    // producer broadcast lands on the edge the consumer is accepted
    for (int i = 0; i < 2; i++) begin
      pick_free(prev);
      send(FUNC_ADD, prev, 1'b1, $random(seed), 1'b1, $random(seed));
      @(negedge clock);
      resolve_src(prev, ar, av);
      pick_free(d);
      if (i == 0) send(FUNC_SUB, d, ar, av, 1'b1, $random(seed));
      else send(FUNC_XOR, d, 1'b1, $random(seed), ar, av);
      wait_drain();
    end
    if (bypass_hits < 2) begin
      $display("same-cycle bypass seen %0d times, expected 2", bypass_hits);
      stop_run();
    end

    // mixed traffic where multiplies finish out of order
    for (int i = 0; i < 40; i++) begin
      if ($random(seed) & 1) func = FUNC_MUL;
      else func = alu_func_t'($unsigned($random(seed)) % 5);
      make_src(ar, av);
      make_src(br, bv);
      pick_free(d);
      send(func, d, ar, av, br, bv);
    end
    wait_drain();

    // long multiply chain and then a crowd waiting on its last tag
    saw_full = 1'b0;
    pick_free(prev);
    send(FUNC_MUL, prev, 1'b1, $random(seed), 1'b1, $random(seed));
    for (int i = 1; i < 4; i++) begin
      resolve_src(prev, ar, av);
      pick_free(d);
      send(FUNC_MUL, d, ar, av, 1'b1, $random(seed));
      prev = d;
    end
    for (int i = 0; i < 10; i++) begin
      resolve_src(prev, ar, av);
      pick_free(d);
      send(alu_func_t'(i % 6), d, ar, av, 1'b1, $random(seed));
    end
    wait_drain();
    check_flag("rs_full during fill", 1'b1, saw_full);

    // idle and empty at the end with the bus parked at zero
    repeat (3) begin
      @(negedge clock);
      check_flag("rs_full", 1'b0, rs_full);
      check_flag("cdb_valid", 1'b0, cdb_valid);
      check_tag("cdb_tag", '0, cdb_tag);
      check_value("cdb_value", '0, cdb_value);
    end
    $display("Simulation completed successfully");
    $finish;
  end

endmodule

`default_nettype wire

// ==== design/cdb_arbiter.sv ====
// cdb arbiter
// lowest-index priority select over lane results, drives cdb and grants
`timescale 1ns/1ns
`default_nettype none

module cdb_arbiter import ooo_pkg::*; #(
  parameter int NUM_LANES = 3
) (
  input  logic [NUM_LANES-1:0] result_valid,
  input  tag_t                 result_tag [NUM_LANES],
  input  word_t                result_value [NUM_LANES],
  output logic [NUM_LANES-1:0] grant,
  output logic                 cdb_valid,
  output tag_t                 cdb_tag,
  output word_t                cdb_value
);

  //////////////////////////////////////////////////////////////////////
  // priority select
  //////////////////////////////////////////////////////////////////////

  // any waiting lane puts something on the bus
  assign cdb_valid = |result_valid;

  // scan from the top, last hit is the lowest index
  // idle bus carries zero tag and value
  always_comb begin
    grant     = '0;
    cdb_tag   = '0;
    cdb_value = '0;
    for (int i = NUM_LANES - 1; i >= 0; i--) begin
      if (result_valid[i]) begin
        // one-hot, drop any higher lane seen earlier
        grant     = '0;
        grant[i]  = 1'b1;
        cdb_tag   = result_tag[i];
        cdb_value = result_value[i];
      end
    end
  end

  // ungranted lanes keep their result for a later cycle

endmodule

`default_nettype wire

// ==== design/fu_lane.sv ====
// one execution lane
// single-cycle alu ops, multi-cycle multiply, result hold until grant
`timescale 1ns/1ns
`default_nettype none

module fu_lane import ooo_pkg::*; #(
  parameter int MULT_LATENCY = 4
) (
  input  logic      clock,
  input  logic      reset,
  input  logic      issue_valid,
  input  alu_func_t issue_func,
  input  tag_t      issue_dest,
  input  word_t     issue_a,
  input  word_t     issue_b,
  input  logic      grant,
  output logic      lane_ready,
  output logic      result_valid,
  output tag_t      result_tag,
  output word_t     result_value
);

  localparam int CNT_W = $clog2(MULT_LATENCY);

  logic             take;
  logic             mult_busy;
  logic             mult_done;
  logic [CNT_W-1:0] mult_count;
  word_t            mult_a;
  word_t            mult_b;

  function automatic word_t alu_calc(input alu_func_t func, input word_t a, input word_t b);
    case (func)
      FUNC_ADD: return a + b;
      FUNC_SUB: return a - b;
      FUNC_AND: return a & b;
      FUNC_OR:  return a | b;
      FUNC_XOR: return a ^ b;
      // low word of the product
      FUNC_MUL: return a * b;
      default:  return '0;
    endcase
  endfunction

  // free, or result leaving this cycle
  assign lane_ready = !mult_busy && (!result_valid || grant);
  assign take       = issue_valid && lane_ready;
  assign mult_done  = mult_busy && (mult_count == CNT_W'(1));

  always_ff @(posedge clock) begin
    if (reset) begin
      result_valid <= 1'b0;
      mult_busy    <= 1'b0;
      mult_count   <= '0;
    end else begin
      if (grant) begin
        result_valid <= 1'b0;
      end
      if (take) begin
        if (issue_func == FUNC_MUL) begin
          mult_busy  <= 1'b1;
          mult_count <= CNT_W'(MULT_LATENCY - 1);
        end else begin
          result_valid <= 1'b1;
        end
      end else if (mult_done) begin
        mult_busy    <= 1'b0;
        result_valid <= 1'b1;
      end else if (mult_busy) begin
        mult_count <= mult_count - 1'b1;
      end
    end
  end

  // payload, held until the grant
  always_ff @(posedge clock) begin
    if (take) begin
      result_tag <= issue_dest;
      mult_a     <= issue_a;
      mult_b     <= issue_b;
      if (issue_func != FUNC_MUL) begin
        result_value <= alu_calc(issue_func, issue_a, issue_b);
      end
    end else if (mult_done) begin
      result_value <= alu_calc(FUNC_MUL, mult_a, mult_b);
    end
  end

endmodule

`default_nettype wire

// ==== design/ooo_core.sv ====
// top level of the out-of-order back end
// reservation station, lane generate loop, cdb arbiter
`timescale 1ns/1ns
`default_nettype none

module ooo_core import ooo_pkg::*; #(
  parameter int RS_SIZE      = 8,
  parameter int NUM_LANES    = 3,
  parameter int MULT_LATENCY = 4
) (
  input  logic      clock,
  input  logic      reset,
  input  logic      dispatch_valid,
  input  alu_func_t dispatch_func,
  input  tag_t      dispatch_dest,
  input  logic      dispatch_a_ready,
  input  operand_t  dispatch_a,
  input  logic      dispatch_b_ready,
  input  operand_t  dispatch_b,
  output logic      rs_full,
  output logic      cdb_valid,
  output tag_t      cdb_tag,
  output word_t     cdb_value
);

  // station to lanes
  logic [NUM_LANES-1:0] issue_valid;
  logic [NUM_LANES-1:0] lane_ready;
  alu_func_t            issue_func [NUM_LANES];
  tag_t                 issue_dest [NUM_LANES];
  word_t                issue_a [NUM_LANES];
  word_t                issue_b [NUM_LANES];

  // lanes to arbiter
  logic [NUM_LANES-1:0] result_valid;
  logic [NUM_LANES-1:0] grant;
  tag_t                 result_tag [NUM_LANES];
  word_t                result_value [NUM_LANES];

  //////////////////////////////////////////////////////////////////////
  // reservation station
  //////////////////////////////////////////////////////////////////////

  reservation_station #(
    .RS_SIZE   (RS_SIZE),
    .NUM_LANES (NUM_LANES)
  ) u_rs (
    .clock            (clock),
    .reset            (reset),
    .dispatch_valid   (dispatch_valid),
    .dispatch_func    (dispatch_func),
    .dispatch_dest    (dispatch_dest),
    .dispatch_a_ready (dispatch_a_ready),
    .dispatch_a       (dispatch_a),
    .dispatch_b_ready (dispatch_b_ready),
    .dispatch_b       (dispatch_b),
    .cdb_valid        (cdb_valid),
    .cdb_tag          (cdb_tag),
    .cdb_value        (cdb_value),
    .lane_ready       (lane_ready),
    .rs_full          (rs_full),
    .issue_valid      (issue_valid),
    .issue_func       (issue_func),
    .issue_dest       (issue_dest),
    .issue_a          (issue_a),
    .issue_b          (issue_b)
  );

  //////////////////////////////////////////////////////////////////////
  // execution lanes
  //////////////////////////////////////////////////////////////////////

  for (genvar i = 0; i < NUM_LANES; i++) begin : g_lane
    fu_lane #(
      .MULT_LATENCY (MULT_LATENCY)
    ) u_lane (
      .clock        (clock),
      .reset        (reset),
      .issue_valid  (issue_valid[i]),
      .issue_func   (issue_func[i]),
      .issue_dest   (issue_dest[i]),
      .issue_a      (issue_a[i]),
      .issue_b      (issue_b[i]),
      .grant        (grant[i]),
      .lane_ready   (lane_ready[i]),
      .result_valid (result_valid[i]),
      .result_tag   (result_tag[i]),
      .result_value (result_value[i])
    );
  end

  // cdb feeds the station wake-up and the outputs
  cdb_arbiter #(
    .NUM_LANES (NUM_LANES)
  ) u_arb (
    .result_valid (result_valid),
    .result_tag   (result_tag),
    .result_value (result_value),
    .grant        (grant),
    .cdb_valid    (cdb_valid),
    .cdb_tag      (cdb_tag),
    .cdb_value    (cdb_value)
  );

endmodule

`default_nettype wire

// ==== design/ooo_pkg.sv ====
// shared definitions for the out-of-order back end
// data and tag widths, alu function encoding, operand word
`default_nettype none

package ooo_pkg;

  // datapath and tag widths
  localparam int WORD_WIDTH = 32;
  localparam int TAG_WIDTH  = 4;

  typedef logic [WORD_WIDTH-1:0] word_t;
  typedef logic [TAG_WIDTH-1:0]  tag_t;

  // function select carried with each instruction
  // mul keeps only the low word of the product
  typedef enum logic [2:0] {
    FUNC_ADD = 3'd0,
    FUNC_SUB = 3'd1,
    FUNC_AND = 3'd2,
    FUNC_OR  = 3'd3,
    FUNC_XOR = 3'd4,
    FUNC_MUL = 3'd5
  } alu_func_t;

  // one source operand word
  // read as a value once ready, else as the tag it waits on
  // the ready bit travels beside it and picks the view
  typedef union packed {
    word_t value;
    struct packed {
      logic [WORD_WIDTH-TAG_WIDTH-1:0] zero;
      tag_t                            tag;
    } pending;
  } operand_t;

endpackage

`default_nettype wire

// ==== design/reservation_station.sv ====
// reservation station
// entry storage, cdb wake-up, dispatch bypass and multi-lane issue select
`timescale 1ns/1ns
`default_nettype none

module reservation_station import ooo_pkg::*; #(
  parameter int RS_SIZE   = 8,
  parameter int NUM_LANES = 3
) (
  input  logic                 clock,
  input  logic                 reset,
  input  logic                 dispatch_valid,
  input  alu_func_t            dispatch_func,
  input  tag_t                 dispatch_dest,
  input  logic                 dispatch_a_ready,
  input  operand_t             dispatch_a,
  input  logic                 dispatch_b_ready,
  input  operand_t             dispatch_b,
  input  logic                 cdb_valid,
  input  tag_t                 cdb_tag,
  input  word_t                cdb_value,
  input  logic [NUM_LANES-1:0] lane_ready,
  output logic                 rs_full,
  output logic [NUM_LANES-1:0] issue_valid,
  output alu_func_t            issue_func [NUM_LANES],
  output tag_t                 issue_dest [NUM_LANES],
  output word_t                issue_a [NUM_LANES],
  output word_t                issue_b [NUM_LANES]
);

  localparam int IDX_W = (RS_SIZE > 1) ? $clog2(RS_SIZE) : 1;

  // entry state
  logic [RS_SIZE-1:0] busy;
  logic [RS_SIZE-1:0] ent_a_ready;
  logic [RS_SIZE-1:0] ent_b_ready;
  alu_func_t          ent_func [RS_SIZE];
  tag_t               ent_dest [RS_SIZE];
  operand_t           ent_a [RS_SIZE];
  operand_t           ent_b [RS_SIZE];

  logic               dispatch_take;
  logic [IDX_W-1:0]   alloc_idx;
  logic [RS_SIZE-1:0] busy_next;
  logic [RS_SIZE-1:0] entry_ready;
  logic [RS_SIZE-1:0] issue_mask;
  logic [IDX_W-1:0]   issue_idx [NUM_LANES];

  // dispatch side, with same-cycle cdb bypass
  logic     a_bypass;
  logic     b_bypass;
  operand_t a_in;
  operand_t b_in;

  //////////////////////////////////////////////////////////////////////
  // dispatch
  //////////////////////////////////////////////////////////////////////

  // held off while full, source keeps the strobe up
  assign dispatch_take = dispatch_valid && !rs_full;

  assign a_bypass = cdb_valid && !dispatch_a_ready && (dispatch_a.pending.tag == cdb_tag);
  assign b_bypass = cdb_valid && !dispatch_b_ready && (dispatch_b.pending.tag == cdb_tag);
  assign a_in     = a_bypass ? operand_t'(cdb_value) : dispatch_a;
  assign b_in     = b_bypass ? operand_t'(cdb_value) : dispatch_b;

  // lowest free entry, scan down so the lowest index wins
  always_comb begin
    alloc_idx = '0;
    for (int k = RS_SIZE - 1; k >= 0; k--) begin
      if (!busy[k]) begin
        alloc_idx = IDX_W'(k);
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // issue select
  //////////////////////////////////////////////////////////////////////

  // only registered ready bits count, wake-up lands next edge
  assign entry_ready = busy & ent_a_ready & ent_b_ready;

  // lanes in index order, each takes the lowest ready entry left
  always_comb begin
    logic [RS_SIZE-1:0] avail;
    avail      = entry_ready;
    issue_mask = '0;
    for (int l = 0; l < NUM_LANES; l++) begin
      issue_valid[l] = 1'b0;
      issue_idx[l]   = '0;
      if (lane_ready[l]) begin
        for (int k = RS_SIZE - 1; k >= 0; k--) begin
          if (avail[k]) begin
            issue_valid[l] = 1'b1;
            issue_idx[l]   = IDX_W'(k);
          end
        end
        // claimed entry is gone for the later lanes
        if (issue_valid[l]) begin
          avail[issue_idx[l]]      = 1'b0;
          issue_mask[issue_idx[l]] = 1'b1;
        end
      end
    end
  end

  always_comb begin
    for (int l = 0; l < NUM_LANES; l++) begin
      issue_func[l] = ent_func[issue_idx[l]];
      issue_dest[l] = ent_dest[issue_idx[l]];
      issue_a[l]    = ent_a[issue_idx[l]].value;
      issue_b[l]    = ent_b[issue_idx[l]].value;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // occupancy
  //////////////////////////////////////////////////////////////////////

  // issued entries free at this edge, dispatch fills one
  always_comb begin
    busy_next = busy & ~issue_mask;
    if (dispatch_take) begin
      busy_next[alloc_idx] = 1'b1;
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      busy    <= '0;
      rs_full <= 1'b0;
    end else begin
      busy    <= busy_next;
      rs_full <= &busy_next;
    end
  end

  // wake-up on cdb match, then the new entry
  always_ff @(posedge clock) begin
    for (int k = 0; k < RS_SIZE; k++) begin
      if (cdb_valid && busy[k] && !ent_a_ready[k] && (ent_a[k].pending.tag == cdb_tag)) begin
        ent_a_ready[k] <= 1'b1;
        ent_a[k].value <= cdb_value;
      end
      if (cdb_valid && busy[k] && !ent_b_ready[k] && (ent_b[k].pending.tag == cdb_tag)) begin
        ent_b_ready[k] <= 1'b1;
        ent_b[k].value <= cdb_value;
      end
    end
    if (dispatch_take) begin
      ent_func[alloc_idx]    <= dispatch_func;
      ent_dest[alloc_idx]    <= dispatch_dest;
      ent_a[alloc_idx]       <= a_in;
      ent_b[alloc_idx]       <= b_in;
      ent_a_ready[alloc_idx] <= dispatch_a_ready || a_bypass;
      ent_b_ready[alloc_idx] <= dispatch_b_ready || b_bypass;
    end
  end

endmodule

`default_nettype wire

// ==== project.f ====
design/ooo_pkg.sv
design/reservation_station.sv
design/fu_lane.sv
design/cdb_arbiter.sv
design/ooo_core.sv
bench/clock_gen.sv
bench/ooo_core_tb.sv
